// ==== cnn_pkg.sv ====
package cnn_pkg;

  localparam int WORD_WIDTH         = 8;
  localparam int UNITS              = 4;
  localparam int KERNEL             = 3;
  localparam int UNITS_EDGES        = UNITS + KERNEL - 1;
  localparam int IM_IN_S_DATA_WORDS = 8;
  localparam int WEIGHTS_DMA_BITS   = 32;
  localparam int WORD_WIDTH_ACC     = 20;
  localparam int LRELU_SHIFT        = 3;
  localparam int FIFO_DEPTH         = 4;
  localparam int FIFO_PTR_BITS      = $clog2(FIFO_DEPTH);
  localparam int KERNEL_BITS        = $clog2(KERNEL);

  typedef logic signed [WORD_WIDTH-1:0]     pixel_t;
  typedef logic signed [WORD_WIDTH-1:0]     weight_t;
  typedef logic signed [WORD_WIDTH_ACC-1:0] acc_t;

  // Row 0 is the top edge row, held in byte lane 0
  typedef struct packed {
    pixel_t [UNITS_EDGES-1:0] px;
  } pixel_col_t;

  // Column 0 is the oldest, leftmost column
  typedef struct packed {
    logic                    last;
    pixel_col_t [KERNEL-1:0] col;
  } window_t;

  // Indexed as w[column][row]
  typedef struct packed {
    weight_t [KERNEL-1:0][KERNEL-1:0] w;
  } kernel_t;

  typedef struct packed {
    acc_t [UNITS-1:0] res;
  } out_beat_t;

  typedef enum logic {
    load_kernel,
    run
  } engine_state_e;

endpackage

// ==== conv_window_shifter.sv ====
`timescale 1ns/1ns

module conv_window_shifter (
  input  logic                aclk,
  input  logic                arst_n,
  input  cnn_pkg::pixel_col_t s_pixels_tdata,
  input  logic                s_pixels_tvalid,
  input  logic                s_pixels_tlast,
  output logic                s_pixels_tready,
  output cnn_pkg::window_t    win,
  output logic                win_valid,
  input  logic                win_ready
);
  import cnn_pkg::*;

  pixel_col_t [KERNEL-1:0] cols;
  logic                    last_q;
  logic [KERNEL_BITS-1:0]  col_cnt;
  logic                    col_fire;

  // Column register doubles as the output register, so it stalls with it
  assign s_pixels_tready = !win_valid || win_ready;
  assign col_fire        = s_pixels_tvalid && s_pixels_tready;

  assign win.col  = cols;
  assign win.last = last_q;

  // Newest column enters at the top index
  always_ff @(posedge aclk) begin
    if (col_fire) begin
      cols   <= {s_pixels_tdata, cols[KERNEL-1:1]};
      last_q <= s_pixels_tlast;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      col_cnt   <= '0;
      win_valid <= 1'b0;
    end else if (col_fire) begin
      // Window complete once two earlier columns of this frame are held
      win_valid <= (col_cnt == KERNEL_BITS'(KERNEL - 1));
      if (s_pixels_tlast) begin
        col_cnt <= '0;
      end else if (col_cnt != KERNEL_BITS'(KERNEL - 1)) begin
        col_cnt <= col_cnt + 1'b1;
      end
    end else if (win_ready) begin
      win_valid <= 1'b0;
    end
  end

endmodule

// ==== window_fifo.sv ====
`timescale 1ns/1ns

module window_fifo (
  input  logic             aclk,
  input  logic             arst_n,
  input  cnn_pkg::window_t wr_data,
  input  logic             wr_valid,
  output logic             wr_ready,
  output cnn_pkg::window_t rd_data,
  output logic             rd_valid,
  input  logic             rd_ready
);
  import cnn_pkg::*;

  window_t                mem [FIFO_DEPTH];
  logic [FIFO_PTR_BITS-1:0] wr_ptr;
  logic [FIFO_PTR_BITS-1:0] rd_ptr;
  logic [FIFO_PTR_BITS:0]   count;
  logic                     wr_fire;
  logic                     rd_fire;

  assign wr_ready = (count != (FIFO_PTR_BITS + 1)'(FIFO_DEPTH));
  assign rd_valid = (count != '0);
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;

  // Fall-through read port
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== conv_engine.sv ====
`timescale 1ns/1ns

module conv_engine (
  input  logic                                 aclk,
  input  logic                                 arst_n,
  input  logic [cnn_pkg::WEIGHTS_DMA_BITS-1:0] s_weights_tdata,
  input  logic                                 s_weights_tvalid,
  input  logic                                 s_weights_tlast,
  output logic                                 s_weights_tready,
  input  cnn_pkg::window_t                     win,
  input  logic                                 win_valid,
  output logic                                 win_ready,
  output cnn_pkg::out_beat_t                   m_tdata,
  output logic                                 m_tvalid,
  output logic                                 m_tlast,
  input  logic                                 m_tready
);
  import cnn_pkg::*;

  engine_state_e        state;
  kernel_t              kernel;
  weight_t [KERNEL-1:0] w_col;
  logic                 w_fire;
  logic                 win_fire;
  logic                 m_fire;
  logic                 s1_valid;
  logic                 s1_last;
  logic                 s1_adv;
  logic                 s2_adv;
  logic                 last_in_flight;
  out_beat_t            sum_d;
  out_beat_t            s1_sum;
  out_beat_t            relu_d;

  assign s_weights_tready = (state == load_kernel);
  assign w_fire           = s_weights_tvalid && s_weights_tready;
  assign w_col            = s_weights_tdata[KERNEL*WORD_WIDTH-1:0];

  assign s2_adv = !m_tvalid || m_tready;
  assign s1_adv = !s1_valid || s2_adv;
  assign m_fire = m_tvalid && m_tready;

  // Hold off the next frame until its own kernel is in
  assign last_in_flight = (s1_valid && s1_last) || (m_tvalid && m_tlast);
  assign win_ready      = (state == run) && s1_adv && !last_in_flight;
  assign win_fire       = win_valid && win_ready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= load_kernel;
    end else begin
      case (state)
        load_kernel: begin
          if (w_fire && s_weights_tlast) begin
            state <= run;
          end
        end
        run: begin
          if (m_fire && m_tlast) begin
            state <= load_kernel;
          end
        end
        default: state <= load_kernel;
      endcase
    end
  end

  // First beat ends up in column 0
  always_ff @(posedge aclk) begin
    if (w_fire) begin
      kernel.w <= {w_col, kernel.w[KERNEL-1:1]};
    end
  end

  // Valid 3x3 sums, one per output row
  always_comb begin
    sum_d = '0;
    for (int u = 0; u < UNITS; u++) begin
      for (int c = 0; c < KERNEL; c++) begin
        for (int r = 0; r < KERNEL; r++) begin
          sum_d.res[u] = sum_d.res[u] +
            WORD_WIDTH_ACC'($signed(win.col[c].px[u + r]) * $signed(kernel.w[c][r]));
        end
      end
    end
  end

  always_comb begin
    relu_d = s1_sum;
    for (int u = 0; u < UNITS; u++) begin
      if (s1_sum.res[u][WORD_WIDTH_ACC-1]) begin
        relu_d.res[u] = $signed(s1_sum.res[u]) >>> LRELU_SHIFT;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (win_fire) begin
      s1_sum <= sum_d;
    end
    if (s2_adv && s1_valid) begin
      m_tdata <= relu_d;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else begin
      if (s1_adv) begin
        s1_valid <= win_fire;
        s1_last  <= win_fire && win.last;
      end
      if (s2_adv) begin
        m_tvalid <= s1_valid;
        m_tlast  <= s1_valid && s1_last;
      end
    end
  end

endmodule

// ==== axis_conv_top.sv ====
`timescale 1ns/1ns

module axis_conv_top (
  input  logic aclk,
  input  logic arst_n,
  input  logic [cnn_pkg::IM_IN_S_DATA_WORDS*cnn_pkg::WORD_WIDTH-1:0]   s_axis_pixels_tdata,
  input  logic [cnn_pkg::IM_IN_S_DATA_WORDS*cnn_pkg::WORD_WIDTH/8-1:0] s_axis_pixels_tkeep,
  input  logic                                                         s_axis_pixels_tvalid,
  input  logic                                                         s_axis_pixels_tlast,
  output logic                                                         s_axis_pixels_tready,
  input  logic [cnn_pkg::WEIGHTS_DMA_BITS-1:0]                         s_axis_weights_tdata,
  input  logic [cnn_pkg::WEIGHTS_DMA_BITS/8-1:0]                       s_axis_weights_tkeep,
  input  logic                                                         s_axis_weights_tvalid,
  input  logic                                                         s_axis_weights_tlast,
  output logic                                                         s_axis_weights_tready,
  output cnn_pkg::out_beat_t                                           m_axis_tdata,
  output logic                                                         m_axis_tvalid,
  output logic                                                         m_axis_tlast,
  input  logic                                                         m_axis_tready
);
  import cnn_pkg::*;

  pixel_col_t pix_col;
  window_t    sh_win;
  window_t    fifo_win;
  logic       sh_valid;
  logic       sh_ready;
  logic       fifo_valid;
  logic       fifo_ready;

  // Full beats only, so tkeep and the spare upper lanes carry nothing
  assign pix_col = s_axis_pixels_tdata[UNITS_EDGES*WORD_WIDTH-1:0];

  conv_window_shifter shifter_i (
    .aclk            (aclk),
    .arst_n          (arst_n),
    .s_pixels_tdata  (pix_col),
    .s_pixels_tvalid (s_axis_pixels_tvalid),
    .s_pixels_tlast  (s_axis_pixels_tlast),
    .s_pixels_tready (s_axis_pixels_tready),
    .win             (sh_win),
    .win_valid       (sh_valid),
    .win_ready       (sh_ready)
  );

  window_fifo fifo_i (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .wr_data  (sh_win),
    .wr_valid (sh_valid),
    .wr_ready (sh_ready),
    .rd_data  (fifo_win),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready)
  );

  conv_engine engine_i (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .s_weights_tdata  (s_axis_weights_tdata),
    .s_weights_tvalid (s_axis_weights_tvalid),
    .s_weights_tlast  (s_axis_weights_tlast),
    .s_weights_tready (s_axis_weights_tready),
    .win              (fifo_win),
    .win_valid        (fifo_valid),
    .win_ready        (fifo_ready),
    .m_tdata          (m_axis_tdata),
    .m_tvalid         (m_axis_tvalid),
    .m_tlast          (m_axis_tlast),
    .m_tready         (m_axis_tready)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic aclk
);

  // 20 ns period
  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

endmodule

// ==== axis_conv_tb.sv ====
`timescale 1ns/1ns

module axis_conv_tb;
  import cnn_pkg::*;

  localparam int NUM_FRAMES = 12;
  localparam int MAX_COLS   = 12;

  typedef struct packed {
    logic      last;
    out_beat_t data;
  } exp_beat_t;

  typedef enum {ready_high, ready_random, ready_low} ready_mode_e;

  logic                                       aclk;
  logic                                       arst_n;
  logic [IM_IN_S_DATA_WORDS*WORD_WIDTH-1:0]   s_axis_pixels_tdata;
  logic [IM_IN_S_DATA_WORDS*WORD_WIDTH/8-1:0] s_axis_pixels_tkeep;
  logic                                       s_axis_pixels_tvalid;
  logic                                       s_axis_pixels_tlast;
  logic                                       s_axis_pixels_tready;
  logic [WEIGHTS_DMA_BITS-1:0]                s_axis_weights_tdata;
  logic [WEIGHTS_DMA_BITS/8-1:0]              s_axis_weights_tkeep;
  logic                                       s_axis_weights_tvalid;
  logic                                       s_axis_weights_tlast;
  logic                                       s_axis_weights_tready;
  out_beat_t                                  m_axis_tdata;
  logic                                       m_axis_tvalid;
  logic                                       m_axis_tlast;
  logic                                       m_axis_tready = 1'b0;
  logic                                       m_fire;

  logic signed [WORD_WIDTH-1:0] pix [NUM_FRAMES][MAX_COLS][UNITS_EDGES];
  logic signed [WORD_WIDTH-1:0] ker [NUM_FRAMES][KERNEL][KERNEL];
  int          ncols [NUM_FRAMES];
  exp_beat_t   exp_q [$];
  exp_beat_t   exp_head;
  logic        exp_avail;
  logic        kernel_seen = 1'b0;
  logic        gaps_on = 1'b0;
  logic        stalled;
  ready_mode_e ready_mode = ready_high;
  logic [31:0] rnd;
  logic [31:0] rnd_ready;
  int          seed = 32'h369f;
  int          total;
  int          cycles = 0;
  int          cycle_limit = 0;

  tb_clock_gen clk_gen_i (.aclk(aclk));

  axis_conv_top axis_conv_top_i (.*);

  assign m_fire = m_axis_tvalid && m_axis_tready;

  task automatic value_error(input string name, input logic [79:0] got, input logic [79:0] exp);
    $display("error %s: got %h, expected %h", name, got, exp);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic plain_error(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  beat_expected: assert property (@(posedge aclk) disable iff (!arst_n) m_fire |-> exp_avail)
    else plain_error("An output beat arrived with no expected beat left");
  data_matches: assert property (@(posedge aclk) disable iff (!arst_n)
    m_fire |-> (m_axis_tdata == exp_head.data))
    else value_error("m_axis_tdata", $sampled(m_axis_tdata), $sampled(exp_head.data));
  last_matches: assert property (@(posedge aclk) disable iff (!arst_n)
    m_fire |-> (m_axis_tlast == exp_head.last))
    else value_error("m_axis_tlast", 80'($sampled(m_axis_tlast)), 80'($sampled(exp_head.last)));
  idle_before_kernel: assert property (@(posedge aclk) disable iff (!arst_n)
    !kernel_seen |-> (!m_axis_tvalid && s_axis_weights_tready))
    else plain_error("Output valid or weights not ready before the first kernel was loaded");

  // Expected queue head is refreshed between edges
  always @(negedge aclk) begin
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) begin
      exp_head = exp_q[0];
    end
  end

  always @(posedge aclk) begin
    if (arst_n && m_fire && exp_q.size() != 0) begin
      exp_q.delete(0);
    end
  end

  always @(negedge aclk) begin
    case (ready_mode)
      ready_random: begin
        rnd_ready = $random(seed);
        m_axis_tready = rnd_ready[0];
      end
      ready_low: m_axis_tready = 1'b0;
      default:   m_axis_tready = 1'b1;
    endcase
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $fatal(1);
    end
  end

  // Kind 0 small positive, kind 1 negative weights, otherwise full signed range
  task automatic make_frame(input int f, input int cols, input int kind);
    ncols[f] = cols;
    for (int c = 0; c < KERNEL; c++) begin
      for (int r = 0; r < KERNEL; r++) begin
        rnd = $random(seed);
        ker[f][c][r] = (kind == 0) ? {6'b0, rnd[1:0]} + 8'd1 :
                       (kind == 1) ? ~{5'b0, rnd[2:0]} : rnd[7:0];
      end
    end
    for (int c = 0; c < cols; c++) begin
      for (int r = 0; r < UNITS_EDGES; r++) begin
        rnd = $random(seed);
        pix[f][c][r] = (kind == 0) ? {5'b0, rnd[2:0]} :
                       (kind == 1) ? {4'b0, rnd[3:0]} : rnd[7:0];
      end
    end
  endtask

  // Reference model of the valid 3x3 convolution and leaky ReLU
  task automatic expect_frame(input int f);
    exp_beat_t beat;
    int        sum;
    for (int k = 0; k + KERNEL <= ncols[f]; k++) begin
      beat.last = (k + KERNEL == ncols[f]);
      for (int u = 0; u < UNITS; u++) begin
        sum = 0;
        for (int c = 0; c < KERNEL; c++) begin
          for (int r = 0; r < KERNEL; r++) begin
            sum += int'(pix[f][k + c][u + r]) * int'(ker[f][c][r]);
          end
        end
        if (sum < 0) begin
          sum = sum >>> LRELU_SHIFT;
        end
        beat.data.res[u] = sum[WORD_WIDTH_ACC-1:0];
      end
      exp_q.push_back(beat);
    end
  endtask

  task automatic insert_gap();
    logic [31:0] r;
    if (gaps_on) begin
      r = $random(seed);
      repeat (r[1:0]) @(negedge aclk);
    end
  endtask

  task automatic send_kernel(input int f);
    for (int c = 0; c < KERNEL; c++) begin
      s_axis_weights_tvalid = 1'b0;
      insert_gap();
      s_axis_weights_tdata  = {8'h00, ker[f][c][2], ker[f][c][1], ker[f][c][0]};
      s_axis_weights_tkeep  = 4'h7;
      s_axis_weights_tlast  = (c == KERNEL - 1);
      s_axis_weights_tvalid = 1'b1;
      @(posedge aclk);
      while (!s_axis_weights_tready) @(posedge aclk);
      @(negedge aclk);
    end
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tlast  = 1'b0;
    kernel_seen = 1'b1;
  endtask

  task automatic send_pixels(input int f);
    logic [IM_IN_S_DATA_WORDS*WORD_WIDTH-1:0] beat;
    for (int c = 0; c < ncols[f]; c++) begin
      s_axis_pixels_tvalid = 1'b0;
      insert_gap();
      beat = '0;
      for (int r = 0; r < UNITS_EDGES; r++) begin
        beat[r*WORD_WIDTH +: WORD_WIDTH] = pix[f][c][r];
      end
      s_axis_pixels_tdata  = beat;
      s_axis_pixels_tkeep  = 8'h3f;
      s_axis_pixels_tlast  = (c == ncols[f] - 1);
      s_axis_pixels_tvalid = 1'b1;
      @(posedge aclk);
      while (!s_axis_pixels_tready) @(posedge aclk);
      @(negedge aclk);
    end
    s_axis_pixels_tvalid = 1'b0;
    s_axis_pixels_tlast  = 1'b0;
  endtask

  task automatic run_frame(input int f);
    expect_frame(f);
    send_kernel(f);
    send_pixels(f);
  endtask

  initial begin
    arst_n = 1'b0;
    s_axis_pixels_tdata = '0;
    s_axis_pixels_tkeep = '0;
    s_axis_pixels_tvalid = 1'b0;
    s_axis_pixels_tlast = 1'b0;
    s_axis_weights_tdata = '0;
    s_axis_weights_tkeep = '0;
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tlast = 1'b0;
    make_frame(0, 6, 0);
    make_frame(1, 6, 1);
    make_frame(2, 5, 2);
    make_frame(3, 7, 2);
    make_frame(4, 4, 2);
    for (int f = 5; f < NUM_FRAMES - 1; f++) begin
      rnd = $random(seed);
      make_frame(f, 3 + int'(rnd[2:0]), 2);
    end
    make_frame(NUM_FRAMES - 1, MAX_COLS, 2);
    total = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      total += ncols[f] + KERNEL;
    end
    cycle_limit = 40 * total;
    repeat (16) @(negedge aclk);
    arst_n = 1'b1;
    @(negedge aclk);
    // Directed frames, then random gaps and back-pressure
    // Frame 0 waits in the FIFO until its kernel is in
    expect_frame(0);
    send_pixels(0);
    send_kernel(0);
    for (int f = 1; f < 5; f++) begin
      run_frame(f);
    end
    gaps_on = 1'b1;
    ready_mode = ready_random;
    for (int f = 5; f < NUM_FRAMES - 1; f++) begin
      run_frame(f);
    end
    gaps_on = 1'b0;
    expect_frame(NUM_FRAMES - 1);
    send_kernel(NUM_FRAMES - 1);
    ready_mode = ready_low;
    fork
      send_pixels(NUM_FRAMES - 1);
      begin
        stalled = 1'b0;
        for (int i = 0; i < 40 && !stalled; i++) begin
          @(negedge aclk);
          stalled = !s_axis_pixels_tready;
        end
        pixels_stalled: assert (stalled)
          else plain_error("s_axis_pixels_tready never went low while m_axis_tready was low");
        ready_mode = ready_high;
      end
    join
    while (exp_q.size() != 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
    if (!m_axis_tvalid) begin
      $display("Regression passed");
      $finish;
    end else begin
      plain_error("An extra output beat is pending after the last expected beat");
    end
  end

endmodule

// ==== list.f ====
cnn_pkg.sv
conv_window_shifter.sv
window_fifo.sv
conv_engine.sv
axis_conv_top.sv
tb_clock_gen.sv
axis_conv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || { echo "Cannot enter the project directory"; exit 1; }

if ! rm -rf obj_dir; then
  echo "Cannot remove the old build directory"
  exit 1
fi

if ! verilator --binary --timing --assert --top-module axis_conv_tb -f list.f -o sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qx "Regression passed" sim.log; then
  exit 0
fi
echo "Simulation failed with exit status ${run_status}"
exit 1
